/* bench/cgra_mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

// Read channel model. Serves up to three loaded words, one per request,
// each after a random delay of 1 to 6 cycles.
module cgra_mem_model (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          restart,
  input  wire [1:0]                    word_count,
  input  wire [cgra_pkg::WIDE_W-1:0]   words [3],
  input  wire                          request_read,
  output logic                         available_read,
  output logic                         data_valid,
  output logic [cgra_pkg::WIDE_W-1:0]  read_data
);

  logic [1:0] requested; // Words asked for so far.
  logic [1:0] pend_idx;
  logic       busy;
  logic [2:0] wait_cnt;

  assign available_read = (requested < word_count);

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      requested  <= 2'd0;
      pend_idx   <= 2'd0;
      busy       <= 1'b0;
      wait_cnt   <= 3'd0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= 1'b0;
      if (request_read) begin
        busy      <= 1'b1;
        pend_idx  <= requested;
        requested <= requested + 2'd1;
        wait_cnt  <= 3'($urandom % 6); // Extra cycles before the answer.
      end else if (busy) begin
        if (wait_cnt == 3'd0) begin
          data_valid <= 1'b1;
          read_data  <= words[pend_idx];
          busy       <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_cgra_fetch_pair.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cgra_fetch_pair;

  localparam int SEED       = 34184;
  localparam int MAX_WORDS  = 3;
  localparam int STYLE_RAND = 0;
  localparam int STYLE_ONES = 1;
  localparam int STYLE_IDX  = 2;
  localparam int NUM_CASES  = 9;

  localparam logic [cgra_pkg::OP_W-1:0] CASE_OP [NUM_CASES] = '{
    cgra_pkg::OP_ADD, cgra_pkg::OP_SUB, cgra_pkg::OP_MUL,
    cgra_pkg::OP_MAX, cgra_pkg::OP_ADD, cgra_pkg::OP_SUB,
    cgra_pkg::OP_MUL, cgra_pkg::OP_MAX, cgra_pkg::OP_ADD
  };
  localparam int CASE_WORDS [NUM_CASES] = '{1, 2, 3, 2, 1, 2, 1, 3, 3};
  localparam int CASE_STYLE [NUM_CASES] = '{
    STYLE_IDX, STYLE_RAND, STYLE_RAND,
    STYLE_RAND, STYLE_ONES, STYLE_IDX,
    STYLE_ONES, STYLE_IDX, STYLE_RAND
  };

  logic                          clk;
  logic                          rst;
  logic                          en;
  logic [cgra_pkg::OP_W-1:0]     op;
  logic                          restart;
  logic [1:0]                    word_count;
  logic [cgra_pkg::WIDE_W-1:0]   a_words [MAX_WORDS];
  logic [cgra_pkg::WIDE_W-1:0]   b_words [MAX_WORDS];
  logic                          a_available_read;
  logic                          a_request_read;
  logic                          a_data_valid;
  logic [cgra_pkg::WIDE_W-1:0]   a_read_data;
  logic                          b_available_read;
  logic                          b_request_read;
  logic                          b_data_valid;
  logic [cgra_pkg::WIDE_W-1:0]   b_read_data;
  logic [cgra_pkg::LANE_W-1:0]   result;
  logic                          result_valid;

  logic [cgra_pkg::LANE_W-1:0]   got [$]; // Every result seen so far.
  int                            a_reqs = 0;
  int                            b_reqs = 0;

  cgra_fetch_pair DUT (
    .clk              (clk),
    .rst              (rst),
    .en               (en),
    .op               (op),
    .a_available_read (a_available_read),
    .a_request_read   (a_request_read),
    .a_data_valid     (a_data_valid),
    .a_read_data      (a_read_data),
    .b_available_read (b_available_read),
    .b_request_read   (b_request_read),
    .b_data_valid     (b_data_valid),
    .b_read_data      (b_read_data),
    .result           (result),
    .result_valid     (result_valid)
  );

  cgra_mem_model mem_a (
    .clk            (clk),
    .rst            (rst),
    .restart        (restart),
    .word_count     (word_count),
    .words          (a_words),
    .request_read   (a_request_read),
    .available_read (a_available_read),
    .data_valid     (a_data_valid),
    .read_data      (a_read_data)
  );

  cgra_mem_model mem_b (
    .clk            (clk),
    .rst            (rst),
    .restart        (restart),
    .word_count     (word_count),
    .words          (b_words),
    .request_read   (b_request_read),
    .available_read (b_available_read),
    .data_valid     (b_data_valid),
    .read_data      (b_read_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Collects results and counts request pulses.
  always @(negedge clk) begin
    if (result_valid) begin
      got.push_back(result);
    end
    if (a_request_read) begin
      a_reqs <= a_reqs + 1;
    end
    if (b_request_read) begin
      b_reqs <= b_reqs + 1;
    end
  end

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h",
               $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Check on %s did not hold", name);
    end
  endtask

  // Lane l of word w sits at bits l*16 upward.
  function automatic logic [cgra_pkg::WIDE_W-1:0] make_word(input int style,
                                                            input int stream,
                                                            input int word_idx);
    logic [cgra_pkg::WIDE_W-1:0] word;
    logic [cgra_pkg::LANE_W-1:0] v;
    int                          idx;
    word = '0;
    for (int l = 0; l < cgra_pkg::LANES; l++) begin
      idx = word_idx * cgra_pkg::LANES + l;
      if (style == STYLE_RAND) begin
        v = 16'($urandom);
      end else if (style == STYLE_ONES) begin
        v = '1;
      end else if (stream == 0) begin
        v = 16'(idx);
      end else begin
        v = 16'(2 * idx + 5); // B above A, so subtract wraps.
      end
      word[l*cgra_pkg::LANE_W +: cgra_pkg::LANE_W] = v;
    end
    return word;
  endfunction

  function automatic logic [cgra_pkg::LANE_W-1:0] apply_op(
      input logic [cgra_pkg::OP_W-1:0] code,
      input logic [cgra_pkg::LANE_W-1:0] a,
      input logic [cgra_pkg::LANE_W-1:0] b);
    logic [2*cgra_pkg::LANE_W-1:0] prod;
    prod = a * b;
    case (code)
      cgra_pkg::OP_ADD: return a + b;
      cgra_pkg::OP_SUB: return a - b;
      cgra_pkg::OP_MUL: return prod[cgra_pkg::LANE_W-1:0];
      default:          return (a > b) ? a : b;
    endcase
  endfunction

  initial begin
    int                          n;
    int                          exp_count;
    int                          res_base;
    int                          a_base;
    int                          b_base;
    logic [cgra_pkg::LANE_W-1:0] a_val;
    logic [cgra_pkg::LANE_W-1:0] b_val;
    logic [cgra_pkg::LANE_W-1:0] exp_val;
    void'($urandom(SEED));
    rst        <= 1'b1;
    en         <= 1'b0;
    op         <= cgra_pkg::OP_ADD;
    restart    <= 1'b0;
    word_count <= 2'd0;
    for (int w = 0; w < MAX_WORDS; w++) begin
      a_words[w] <= '0;
      b_words[w] <= '0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int c = 0; c < NUM_CASES; c++) begin
      n = CASE_WORDS[c];
      exp_count = n * cgra_pkg::LANES;
      @(posedge clk);
      en <= 1'b0;
      for (int w = 0; w < MAX_WORDS; w++) begin
        if (w < n) begin
          a_words[w] <= make_word(CASE_STYLE[c], 0, w);
          b_words[w] <= make_word(CASE_STYLE[c], 1, w);
        end else begin
          a_words[w] <= '0;
          b_words[w] <= '0;
        end
      end
      word_count <= 2'(n);
      op         <= CASE_OP[c];
      restart    <= 1'b1;
      @(posedge clk);
      restart <= 1'b0;

      // Memory offers words, but nothing moves while en is low.
      repeat (3) begin
        @(negedge clk);
        check("a_request_read", 64'(a_request_read), 64'd0);
        check("b_request_read", 64'(b_request_read), 64'd0);
        check("result_valid", 64'(result_valid), 64'd0);
      end
      res_base = got.size();
      a_base   = a_reqs;
      b_base   = b_reqs;
      @(posedge clk);
      en <= 1'b1;

      while (got.size() - res_base < exp_count) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk); // Room for a stray extra result.

      check("result count", 64'(got.size() - res_base), 64'(exp_count));
      check("a_request_read count", 64'(a_reqs - a_base), 64'(n));
      check("b_request_read count", 64'(b_reqs - b_base), 64'(n));
      for (int w = 0; w < n; w++) begin
        for (int l = 0; l < cgra_pkg::LANES; l++) begin
          a_val   = a_words[w][l*cgra_pkg::LANE_W +: cgra_pkg::LANE_W];
          b_val   = b_words[w][l*cgra_pkg::LANE_W +: cgra_pkg::LANE_W];
          exp_val = apply_op(CASE_OP[c], a_val, b_val);
          check("result", 64'(got[res_base + w * cgra_pkg::LANES + l]), 64'(exp_val));
        end
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

  // Budget of 32 pops plus fetch overhead per word, and idle gaps per case.
  initial begin
    int total;
    int limit;
    total = 0;
    for (int c = 0; c < NUM_CASES; c++) begin
      total += CASE_WORDS[c];
    end
    limit = total * (cgra_pkg::LANES + 10) + NUM_CASES * 20 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: results stopped arriving within %0d cycles", limit);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

/* build.f */
common/cgra_pkg.sv
fetch/cgra_fetch_data.sv
verilog/cgra_stream_alu.sv
verilog/cgra_fetch_pair.sv
bench/cgra_mem_model.sv
bench/tb_cgra_fetch_pair.sv

/* common/cgra_pkg.sv */
`default_nettype none

package cgra_pkg;

  // Memory side.
  localparam int WIDE_W = 512; // One read word.

  // Lane side.
  localparam int LANE_W = 16; // Element and result width.
  localparam int LANES  = WIDE_W / LANE_W;

  // Stream ALU opcodes.
  localparam int OP_W = 2;

  localparam logic [OP_W-1:0] OP_ADD = 2'd0; // Modulo 2^16.
  localparam logic [OP_W-1:0] OP_SUB = 2'd1; // A minus B modulo 2^16.
  localparam logic [OP_W-1:0] OP_MUL = 2'd2; // Low half of the product.
  localparam logic [OP_W-1:0] OP_MAX = 2'd3; // Unsigned.

endpackage

`default_nettype wire

/* fetch/cgra_fetch_data.sv */
`timescale 1ns/10ps
`default_nettype none

// Reads one wide word at a time into a single-word buffer and serves it out
// one lane per pop, lowest lane first. The next read overlaps the drain.
module cgra_fetch_data (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          en,
  input  wire                          available_read,
  output logic                         request_read,
  input  wire                          data_valid,
  input  wire [cgra_pkg::WIDE_W-1:0]   read_data,
  input  wire                          pop_data,
  output logic                         available_pop,
  output logic [cgra_pkg::LANE_W-1:0]  data_out
);

  logic                        waiting;     // Request out, word not back yet.
  logic                        has_buffer;  // Buffer holds an unread word.
  logic                        buffer_read; // Buffer went to the lane register.
  logic [cgra_pkg::WIDE_W-1:0] buffer;
  logic [cgra_pkg::WIDE_W-1:0] lanes;
  logic [cgra_pkg::LANES-1:0]  count;       // One-hot lane position.
  logic                        last_lane;
  logic                        pop;
  logic                        load;
  logic                        shift;

  assign data_out  = lanes[cgra_pkg::LANE_W-1:0];
  assign last_lane = count[cgra_pkg::LANES-1];
  assign pop       = pop_data & available_pop;

  // First word when idle, or the next word right behind the last lane.
  assign load  = en & has_buffer & (~available_pop | (pop & last_lane));
  assign shift = en & pop & ~load;

  // Read machine with idle, waiting and buffered states.
  always_ff @(posedge clk) begin
    if (rst) begin
      waiting      <= 1'b0;
      has_buffer   <= 1'b0;
      request_read <= 1'b0;
    end else begin
      request_read <= 1'b0;
      if (en) begin
        if (has_buffer) begin
          if (buffer_read) begin
            has_buffer <= 1'b0;
          end
        end else if (waiting) begin
          if (data_valid) begin
            waiting    <= 1'b0;
            has_buffer <= 1'b1;
          end
        end else if (available_read) begin
          request_read <= 1'b1;
          waiting      <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en && waiting && !has_buffer && data_valid) begin
      buffer <= read_data;
    end
  end

  // Control machine for lane position and pop availability.
  always_ff @(posedge clk) begin
    if (rst) begin
      available_pop <= 1'b0;
      buffer_read   <= 1'b0;
      count         <= '0;
    end else if (en) begin
      buffer_read <= load;
      if (load) begin
        available_pop <= 1'b1;
        count         <= {{(cgra_pkg::LANES-1){1'b0}}, 1'b1};
      end else if (pop) begin
        if (last_lane) begin
          available_pop <= 1'b0; // Starved until the next word lands.
        end
        count <= {count[cgra_pkg::LANES-2:0], 1'b0};
      end
    end
  end

  // Lane register, shifted down one lane per pop.
  always_ff @(posedge clk) begin
    if (load) begin
      lanes <= buffer;
    end else if (shift) begin
      lanes <= {{cgra_pkg::LANE_W{1'b0}},
                lanes[cgra_pkg::WIDE_W-1:cgra_pkg::LANE_W]};
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module tb_cgra_fetch_pair \
  -f build.f -o tb_cgra_fetch_pair > build.log 2>&1 \
  || { cat build.log; echo "FAIL: build error"; exit 1; }

./obj_dir/tb_cgra_fetch_pair > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
  || { echo "FAIL: run ended without a result"; exit 1; }

echo "PASS"
exit 0

/* verilog/cgra_fetch_pair.sv */
`timescale 1ns/10ps
`default_nettype none

// Two fetchers feeding one stream ALU.
module cgra_fetch_pair (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          en,
  input  wire [cgra_pkg::OP_W-1:0]     op,
  input  wire                          a_available_read,
  output logic                         a_request_read,
  input  wire                          a_data_valid,
  input  wire [cgra_pkg::WIDE_W-1:0]   a_read_data,
  input  wire                          b_available_read,
  output logic                         b_request_read,
  input  wire                          b_data_valid,
  input  wire [cgra_pkg::WIDE_W-1:0]   b_read_data,
  output logic [cgra_pkg::LANE_W-1:0]  result,
  output logic                         result_valid
);

  logic                        a_available;
  logic                        a_pop;
  logic [cgra_pkg::LANE_W-1:0] a_data;
  logic                        b_available;
  logic                        b_pop;
  logic [cgra_pkg::LANE_W-1:0] b_data;

  cgra_fetch_data fetch_a (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .available_read (a_available_read),
    .request_read   (a_request_read),
    .data_valid     (a_data_valid),
    .read_data      (a_read_data),
    .pop_data       (a_pop),
    .available_pop  (a_available),
    .data_out       (a_data)
  );

  cgra_fetch_data fetch_b (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .available_read (b_available_read),
    .request_read   (b_request_read),
    .data_valid     (b_data_valid),
    .read_data      (b_read_data),
    .pop_data       (b_pop),
    .available_pop  (b_available),
    .data_out       (b_data)
  );

  // Stalls whenever either stream runs dry.
  cgra_stream_alu alu (
    .clk          (clk),
    .rst          (rst),
    .en           (en),
    .op           (op),
    .a_available  (a_available),
    .a_data       (a_data),
    .b_available  (b_available),
    .b_data       (b_data),
    .a_pop        (a_pop),
    .b_pop        (b_pop),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

/* verilog/cgra_stream_alu.sv */
`timescale 1ns/10ps
`default_nettype none

// Pops both lane streams in lockstep and applies one element-wise operation.
module cgra_stream_alu (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          en,
  input  wire [cgra_pkg::OP_W-1:0]     op,
  input  wire                          a_available,
  input  wire [cgra_pkg::LANE_W-1:0]   a_data,
  input  wire                          b_available,
  input  wire [cgra_pkg::LANE_W-1:0]   b_data,
  output logic                         a_pop,
  output logic                         b_pop,
  output logic [cgra_pkg::LANE_W-1:0]  result,
  output logic                         result_valid
);

  logic                        pop;
  logic [cgra_pkg::LANE_W-1:0] sum;
  logic [cgra_pkg::LANE_W-1:0] diff;
  logic [cgra_pkg::LANE_W-1:0] prod_lo;
  logic [cgra_pkg::LANE_W-1:0] max_val;
  logic [cgra_pkg::LANE_W-1:0] op_result;

  // Both or neither, so the pairs stay aligned.
  assign pop   = en & a_available & b_available;
  assign a_pop = pop;
  assign b_pop = pop;

  // All results are lane wide, so the arithmetic wraps.
  assign sum     = a_data + b_data;
  assign diff    = a_data - b_data;
  assign prod_lo = a_data * b_data;
  assign max_val = (a_data > b_data) ? a_data : b_data;

  always_comb begin
    op_result = '0;
    case (op)
      cgra_pkg::OP_ADD: op_result = sum;
      cgra_pkg::OP_SUB: op_result = diff;
      cgra_pkg::OP_MUL: op_result = prod_lo;
      cgra_pkg::OP_MAX: op_result = max_val;
      default:          op_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= pop; // One pulse per popped pair.
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result <= op_result;
    end
  end

endmodule

`default_nettype wire
